// ==== biu/dmem_biu.sv ====
// Bus interface unit, AHB-Lite master
// Address phase driven straight from the strobe
// Data phase state captured on HREADY
// Acknowledge, read data and error return per transfer

module dmem_biu (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Access block side
  input  logic              biu_stb_i,      // Request offered
  output logic              biu_stb_ack_o,  // Address phase taken
  input  dmem_pkg::plen_t   biu_adri_i,
  output dmem_pkg::plen_t   biu_adro_o,     // Address of the answered transfer
  input  dmem_pkg::hsize_t  biu_size_i,
  input  dmem_pkg::hburst_t biu_type_i,
  input  logic              biu_lock_i,
  input  dmem_pkg::hprot_t  biu_prot_i,
  input  logic              biu_we_i,
  input  dmem_pkg::xlen_t   biu_d_i,
  output dmem_pkg::xlen_t   biu_q_o,
  output logic              biu_ack_o,      // Data phase done, OKAY
  output logic              biu_err_o,      // Data phase done, ERROR

  // AHB-Lite master
  output dmem_pkg::plen_t   haddr_o,
  output logic              hwrite_o,
  output dmem_pkg::hsize_t  hsize_o,
  output dmem_pkg::hburst_t hburst_o,
  output logic [3:0]        hprot_o,
  output dmem_pkg::htrans_e htrans_o,
  output logic              hmastlock_o,
  output dmem_pkg::xlen_t   hwdata_o,
  input  dmem_pkg::xlen_t   hrdata_i,
  input  logic              hready_i,
  input  logic              hresp_i         // 1 = ERROR
);

  // Data phase state
  logic            dp_valid;  // A transfer sits in its data phase
  dmem_pkg::plen_t dp_adr;    // Its address, returned with the response
  dmem_pkg::xlen_t dp_wdata;  // Its write data

  //////////////////////////////
  // Address phase

  // The access block keeps the request stable while HREADY is low,
  // so the address phase is a plain copy of the strobe fields
  always_comb begin
    htrans_o = biu_stb_i ? dmem_pkg::NONSEQ : dmem_pkg::IDLE;
  end

  assign haddr_o     = biu_adri_i;
  assign hwrite_o    = biu_we_i;
  assign hsize_o     = biu_size_i;
  assign hburst_o    = biu_type_i;           // SINGLE from the LSU
  assign hprot_o     = {1'b0, biu_prot_i};   // Not cacheable
  assign hmastlock_o = biu_lock_i;

  // Slave samples the address phase when HREADY is high
  assign biu_stb_ack_o = biu_stb_i & hready_i;

  //////////////////////////////
  // Data phase

  // Pipeline advances on HREADY only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dp_valid <= 1'b0;
    end else if (hready_i) begin
      dp_valid <= biu_stb_i;
    end
  end

  // Payload follows the valid flag
  always_ff @(posedge clk_i) begin
    if (hready_i) begin
      dp_adr   <= biu_adri_i;
      dp_wdata <= biu_d_i;
    end
  end

  // Write data one cycle behind the address
  assign hwdata_o = dp_wdata;

  //////////////////////////////
  // Response

  // OKAY completes with HREADY high.
  // ERROR takes two cycles, HREADY low then high, both with HRESP set;
  // only the second one is reported so each transfer answers once
  assign biu_ack_o = dp_valid & hready_i & ~hresp_i;
  assign biu_err_o = dp_valid & hready_i &  hresp_i;

  assign biu_q_o    = hrdata_i;  // Valid with biu_ack_o on reads
  assign biu_adro_o = dp_adr;

endmodule

// ==== common/dmem_defines.svh ====
// Width and depth macros for the data-side access path
// Data word, physical address, transfers in flight
// Error-region address bit used by the memory model

`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// Data word width
`define XLEN 32

// Physical address width
`define PLEN 32

// Max AHB transfers in flight (address + data phase)
`define DEPTH 2

// Address bit selecting the slave error region
`define ERR_BIT 12

`endif

// ==== common/dmem_pkg.sv ====
// Shared types for the data-side access path
// Vector typedefs for data, address and AHB control fields
// AHB-Lite HTRANS encoding

`include "dmem_defines.svh"

package dmem_pkg;

  //////////////////////////////
  // Data and address
  typedef logic [`XLEN-1:0] xlen_t;  // One data word
  typedef logic [`PLEN-1:0] plen_t;  // Physical address

  //////////////////////////////
  // AHB control fields
  typedef logic [2:0] hsize_t;   // Transfer size, HSIZE encoding
  typedef logic [2:0] hburst_t;  // Burst type, HBURST encoding
  typedef logic [2:0] hprot_t;   // Protection, zero-extended on the bus

  // In-flight counter, holds 0..DEPTH
  typedef logic [$clog2(`DEPTH):0] cnt_t;

  //////////////////////////////
  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst pause, never driven here
    NONSEQ = 2'b10,  // First or single transfer
    SEQ    = 2'b11   // Burst continuation
  } htrans_e;

endpackage

// ==== dext/dmem_dext.sv ====
// Data external access block
// Request hold register between CPU and bus interface
// In-flight transfer counter and flush discard counter
// Response gating towards the CPU

module dmem_dext (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clr_i,          // Pipeline flush

  // CPU side
  input  logic              mem_req_i,
  input  dmem_pkg::plen_t   mem_adr_i,
  input  dmem_pkg::hsize_t  mem_size_i,
  input  dmem_pkg::hburst_t mem_type_i,
  input  logic              mem_lock_i,
  input  dmem_pkg::hprot_t  mem_prot_i,
  input  logic              mem_we_i,
  input  dmem_pkg::xlen_t   mem_d_i,
  output logic              mem_adr_ack_o,  // Request accepted
  output dmem_pkg::plen_t   mem_adr_o,
  output dmem_pkg::xlen_t   mem_q_o,
  output logic              mem_ack_o,      // Transfer done
  output logic              mem_err_o,      // Transfer failed

  // Bus interface side
  output logic              biu_stb_o,
  input  logic              biu_stb_ack_i,
  output dmem_pkg::plen_t   biu_adri_o,
  input  dmem_pkg::plen_t   biu_adro_i,
  output dmem_pkg::hsize_t  biu_size_o,
  output dmem_pkg::hburst_t biu_type_o,
  output logic              biu_lock_o,
  output dmem_pkg::hprot_t  biu_prot_o,
  output logic              biu_we_o,
  output dmem_pkg::xlen_t   biu_d_o,
  input  dmem_pkg::xlen_t   biu_q_i,
  input  logic              biu_ack_i,
  input  logic              biu_err_i
);

  logic              hold_req;   // Held copy is valid
  dmem_pkg::plen_t   hold_adr;
  dmem_pkg::hsize_t  hold_size;
  dmem_pkg::hburst_t hold_type;
  logic              hold_lock;
  dmem_pkg::hprot_t  hold_prot;
  logic              hold_we;
  dmem_pkg::xlen_t   hold_d;

  dmem_pkg::cnt_t    inflight;   // Address phases taken, no response yet
  dmem_pkg::cnt_t    discard;    // Responses still to drop after flush
  logic              resp;       // BIU response this cycle
  logic              keep_resp;  // Response goes to the CPU

  //////////////////////////////
  // Request hold
  always_ff @(posedge clk_i) begin
    if (mem_req_i) begin
      hold_adr  <= mem_adr_i;
      hold_size <= mem_size_i;
      hold_type <= mem_type_i;
      hold_lock <= mem_lock_i;
      hold_prot <= mem_prot_i;
      hold_we   <= mem_we_i;
      hold_d    <= mem_d_i;
    end
  end

  // Valid until the BIU takes the address phase, dropped on flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_req <= 1'b0;
    end else if (clr_i) begin
      hold_req <= 1'b0;
    end else begin
      hold_req <= (mem_req_i | hold_req) & ~biu_stb_ack_i;
    end
  end

  //////////////////////////////
  // Transfer bookkeeping
  assign resp = biu_ack_i | biu_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight <= '0;
    end else begin
      case ({biu_stb_ack_i, resp})
        2'b10:   inflight <= inflight + dmem_pkg::cnt_t'(1);
        2'b01:   inflight <= inflight - dmem_pkg::cnt_t'(1);
        default: inflight <= inflight;  // Idle, or one in and one out
      endcase
    end
  end

  // Flush marks every open transfer as stale
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      discard <= '0;
    end else if (clr_i) begin
      // A response in the flush cycle is already dropped
      if (resp && inflight != '0) begin
        discard <= inflight - dmem_pkg::cnt_t'(1);
      end else begin
        discard <= inflight;
      end
    end else if (resp && discard != '0) begin
      discard <= discard - dmem_pkg::cnt_t'(1);
    end
  end

  //////////////////////////////
  // Outputs
  assign biu_stb_o  = (mem_req_i | hold_req) & ~clr_i;  // No new access during flush
  assign biu_adri_o = hold_req ? hold_adr  : mem_adr_i;
  assign biu_size_o = hold_req ? hold_size : mem_size_i;
  assign biu_type_o = hold_req ? hold_type : mem_type_i;
  assign biu_lock_o = hold_req ? hold_lock : mem_lock_i;
  assign biu_prot_o = hold_req ? hold_prot : mem_prot_i;
  assign biu_we_o   = hold_req ? hold_we   : mem_we_i;
  assign biu_d_o    = hold_req ? hold_d    : mem_d_i;

  assign keep_resp     = ~clr_i & (discard == '0);
  assign mem_adr_ack_o = biu_stb_ack_i;
  assign mem_adr_o     = biu_adro_i;
  assign mem_q_o       = biu_q_i;
  assign mem_ack_o     = biu_ack_i & keep_resp;
  assign mem_err_o     = biu_err_i & keep_resp;

endmodule

// ==== dmem_access.f ====
+incdir+common
common/dmem_pkg.sv
dext/dmem_dext.sv
biu/dmem_biu.sv
src/dmem_access_top.sv
verification/tb_ahb_mem.sv
verification/tb_dmem_access.sv

// ==== src/dmem_access_top.sv ====
// Data-side external access path, top level
// Access block and AHB-Lite bus interface unit
// CPU request/response ports and AHB-Lite master ports

module dmem_access_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  // CPU side
  input  logic              mem_req_i,
  input  dmem_pkg::plen_t   mem_adr_i,
  input  dmem_pkg::hsize_t  mem_size_i,
  input  dmem_pkg::hburst_t mem_type_i,
  input  logic              mem_lock_i,
  input  dmem_pkg::hprot_t  mem_prot_i,
  input  logic              mem_we_i,
  input  dmem_pkg::xlen_t   mem_d_i,
  input  logic              clr_i,
  output logic              mem_adr_ack_o,
  output dmem_pkg::plen_t   mem_adr_o,
  output dmem_pkg::xlen_t   mem_q_o,
  output logic              mem_ack_o,
  output logic              mem_err_o,

  // AHB-Lite master
  output dmem_pkg::plen_t   haddr_o,
  output logic              hwrite_o,
  output dmem_pkg::hsize_t  hsize_o,
  output dmem_pkg::hburst_t hburst_o,
  output logic [3:0]        hprot_o,
  output dmem_pkg::htrans_e htrans_o,
  output logic              hmastlock_o,
  output dmem_pkg::xlen_t   hwdata_o,
  input  dmem_pkg::xlen_t   hrdata_i,
  input  logic              hready_i,
  input  logic              hresp_i
);

  //////////////////////////////
  // Access block to BIU
  logic              biu_stb;
  logic              biu_stb_ack;
  dmem_pkg::plen_t   biu_adri;
  dmem_pkg::plen_t   biu_adro;
  dmem_pkg::hsize_t  biu_size;
  dmem_pkg::hburst_t biu_type;
  logic              biu_lock;
  dmem_pkg::hprot_t  biu_prot;
  logic              biu_we;
  dmem_pkg::xlen_t   biu_d;
  dmem_pkg::xlen_t   biu_q;
  logic              biu_ack;
  logic              biu_err;

  // Request hold and flush filtering
  dmem_dext u_dext (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clr_i         (clr_i),
    .mem_req_i     (mem_req_i),
    .mem_adr_i     (mem_adr_i),
    .mem_size_i    (mem_size_i),
    .mem_type_i    (mem_type_i),
    .mem_lock_i    (mem_lock_i),
    .mem_prot_i    (mem_prot_i),
    .mem_we_i      (mem_we_i),
    .mem_d_i       (mem_d_i),
    .mem_adr_ack_o (mem_adr_ack_o),
    .mem_adr_o     (mem_adr_o),
    .mem_q_o       (mem_q_o),
    .mem_ack_o     (mem_ack_o),
    .mem_err_o     (mem_err_o),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_adri_o    (biu_adri),
    .biu_adro_i    (biu_adro),
    .biu_size_o    (biu_size),
    .biu_type_o    (biu_type),
    .biu_lock_o    (biu_lock),
    .biu_prot_o    (biu_prot),
    .biu_we_o      (biu_we),
    .biu_d_o       (biu_d),
    .biu_q_i       (biu_q),
    .biu_ack_i     (biu_ack),
    .biu_err_i     (biu_err)
  );

  // AHB-Lite master port
  dmem_biu u_biu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .biu_stb_i     (biu_stb),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_adri_i    (biu_adri),
    .biu_adro_o    (biu_adro),
    .biu_size_i    (biu_size),
    .biu_type_i    (biu_type),
    .biu_lock_i    (biu_lock),
    .biu_prot_i    (biu_prot),
    .biu_we_i      (biu_we),
    .biu_d_i       (biu_d),
    .biu_q_o       (biu_q),
    .biu_ack_o     (biu_ack),
    .biu_err_o     (biu_err),
    .haddr_o       (haddr_o),
    .hwrite_o      (hwrite_o),
    .hsize_o       (hsize_o),
    .hburst_o      (hburst_o),
    .hprot_o       (hprot_o),
    .htrans_o      (htrans_o),
    .hmastlock_o   (hmastlock_o),
    .hwdata_o      (hwdata_o),
    .hrdata_i      (hrdata_i),
    .hready_i      (hready_i),
    .hresp_i       (hresp_i)
  );

endmodule

// ==== verification/tb_ahb_mem.sv ====
// AHB-Lite slave memory model for the testbench
// 256-word array, unwritten words read as address XOR pattern
// Random 0..2 wait states, two-cycle ERROR response on ERR_BIT

`include "dmem_defines.svh"

module tb_ahb_mem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              zero_wait_i,  // No wait states
  input  dmem_pkg::plen_t   haddr_i,
  input  logic              hwrite_i,
  input  dmem_pkg::htrans_e htrans_i,
  input  dmem_pkg::xlen_t   hwdata_i,
  output dmem_pkg::xlen_t   hrdata_o,
  output logic              hready_o,
  output logic              hresp_o,
  output logic              dphase_o      // Data phase in progress
);
  timeunit 1ns;
  timeprecision 100ps;

  dmem_pkg::xlen_t mem [256];
  logic            written [256];        // Word holds written data
  integer          seed = 32'hd7f6_2719;

  logic            dp_act;    // Data phase active
  logic            dp_we;
  logic            dp_err;    // Address in the error region
  logic            err_done;  // First ERROR cycle done
  dmem_pkg::plen_t dp_adr;
  logic [1:0]      wait_cnt;  // Wait states left
  logic [7:0]      idx;

  assign idx      = dp_adr[9:2];
  assign dphase_o = dp_act;
  assign hrdata_o = written[idx] ? mem[idx] : (dp_adr ^ 32'hA5A5_0000);

  //////////////////////////////
  // Response
  always_comb begin
    hready_o = 1'b1;
    hresp_o  = 1'b0;
    if (dp_act) begin
      if (wait_cnt != 2'd0) begin
        hready_o = 1'b0;
      end else if (dp_err) begin
        hready_o = err_done;  // Low, then high
        hresp_o  = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Phase tracking
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dp_act   <= 1'b0;
      dp_we    <= 1'b0;
      dp_err   <= 1'b0;
      err_done <= 1'b0;
      dp_adr   <= '0;
      wait_cnt <= 2'd0;
      for (int i = 0; i < 256; i++) begin
        written[i] <= 1'b0;
      end
    end else begin
      if (dp_act && !hready_o) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          err_done <= 1'b1;  // Second ERROR cycle next
        end
      end
      // Write lands when the data phase completes OKAY
      if (dp_act && hready_o && dp_we && !dp_err) begin
        mem[idx]     <= hwdata_i;
        written[idx] <= 1'b1;
      end
      if (hready_o) begin
        dp_act   <= (htrans_i == dmem_pkg::NONSEQ);
        dp_adr   <= haddr_i;
        dp_we    <= hwrite_i;
        dp_err   <= haddr_i[`ERR_BIT];
        err_done <= 1'b0;
        wait_cnt <= zero_wait_i ? 2'd0 : 2'({$random(seed)} % 3);
      end
    end
  end

endmodule

// ==== verification/tb_dmem_access.sv ====
// Testbench for the data-side access path
// Clock, reset, CPU-side stimulus, AHB slave memory
// Expected-response queue with shadow memory
// Concurrent assertions on every CPU response

`include "dmem_defines.svh"

module tb_dmem_access;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RAND   = 40;
  // About 80 transfers of up to 5 cycles each, plus drains, with wide margin
  localparam int MAX_CYCLES = 2000;

  typedef struct {
    dmem_pkg::plen_t adr;
    logic            we;
    dmem_pkg::xlen_t q;     // Expected read data
    logic            err;   // Error region
    logic            drop;  // Hit by a flush
  } resp_t;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req;
  dmem_pkg::plen_t   req_adr;
  logic              req_we;
  dmem_pkg::xlen_t   req_d;
  logic              req_lock;
  dmem_pkg::hprot_t  req_prot;
  logic              clr;
  logic              zero_wait;
  logic              adr_ack;
  dmem_pkg::plen_t   rsp_adr;
  dmem_pkg::xlen_t   rsp_q;
  logic              rsp_ack;
  logic              rsp_err;
  dmem_pkg::plen_t   haddr;
  logic              hwrite;
  dmem_pkg::hsize_t  hsize;
  dmem_pkg::hburst_t hburst;
  logic [3:0]        hprot;
  logic              hmastlock;
  dmem_pkg::htrans_e htrans;
  dmem_pkg::xlen_t   hwdata;
  dmem_pkg::xlen_t   hrdata;
  logic              hready;
  logic              hresp;
  logic              dphase;
  logic              bus_done;  // Slave completes a data phase

  resp_t             exp_q [$];
  dmem_pkg::xlen_t   shadow [256];
  logic              shadow_ok [256];
  logic              head_valid = 1'b0;
  dmem_pkg::plen_t   head_adr;
  dmem_pkg::xlen_t   head_q;
  logic              head_we;
  logic              head_err;
  logic              head_drop;

  integer            seed = 32'hd7f6_2719;
  string             test_name = "none";
  int                test_base;
  int                err_cnt = 0;
  int                n_tests = 0;
  int                n_failed = 0;
  int                n_resp = 0;
  int                cycles = 0;

  always #4 clk = ~clk;

  assign bus_done = dphase & hready;

  dmem_access_top u_dmem_access_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .mem_req_i     (req),
    .mem_adr_i     (req_adr),
    .mem_size_i    (3'b010),    // Word
    .mem_type_i    (3'b000),    // SINGLE
    .mem_lock_i    (req_lock),
    .mem_prot_i    (req_prot),
    .mem_we_i      (req_we),
    .mem_d_i       (req_d),
    .clr_i         (clr),
    .mem_adr_ack_o (adr_ack),
    .mem_adr_o     (rsp_adr),
    .mem_q_o       (rsp_q),
    .mem_ack_o     (rsp_ack),
    .mem_err_o     (rsp_err),
    .haddr_o       (haddr),
    .hwrite_o      (hwrite),
    .hsize_o       (hsize),
    .hburst_o      (hburst),
    .hprot_o       (hprot),
    .htrans_o      (htrans),
    .hmastlock_o   (hmastlock),
    .hwdata_o      (hwdata),
    .hrdata_i      (hrdata),
    .hready_i      (hready),
    .hresp_i       (hresp)
  );

  tb_ahb_mem u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .zero_wait_i (zero_wait),
    .haddr_i     (haddr),
    .hwrite_i    (hwrite),
    .htrans_i    (htrans),
    .hwdata_i    (hwdata),
    .hrdata_o    (hrdata),
    .hready_o    (hready),
    .hresp_o     (hresp),
    .dphase_o    (dphase)
  );

  //////////////////////////////
  // Reference model
  always @(posedge clk) begin
    resp_t      e;
    logic [7:0] si;
    if (!rst_n) begin
      exp_q.delete();
      foreach (shadow_ok[i]) begin
        shadow_ok[i] = 1'b0;
      end
    end else begin
      if (bus_done && exp_q.size() != 0) begin
        void'(exp_q.pop_front());  // Oldest transfer answered
        n_resp++;
      end
      if (clr) begin
        foreach (exp_q[i]) begin
          exp_q[i].drop = 1'b1;
        end
      end
      if (adr_ack) begin
        si     = req_adr[9:2];
        e.adr  = req_adr;
        e.we   = req_we;
        e.err  = req_adr[`ERR_BIT];
        e.drop = 1'b0;
        e.q    = shadow_ok[si] ? shadow[si] : (req_adr ^ 32'hA5A5_0000);
        if (req_we && !e.err) begin  // Error-region writes never land
          shadow[si]    = req_d;
          shadow_ok[si] = 1'b1;
        end
        exp_q.push_back(e);
      end
    end
    head_valid = (exp_q.size() != 0);
    if (head_valid) begin
      head_adr  = exp_q[0].adr;
      head_q    = exp_q[0].q;
      head_we   = exp_q[0].we;
      head_err  = exp_q[0].err;
      head_drop = exp_q[0].drop;
    end
  end

  //////////////////////////////
  // Error reporting
  task automatic value_mismatch(input string what, input logic [31:0] expv,
                                input logic [31:0] actv);
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, expv, actv);
    err_cnt++;
  endtask

  task automatic note_error(input string msg);
    $display("Error in test %s: %s", test_name, msg);
    err_cnt++;
  endtask

  //////////////////////////////
  // Assertions
  a_reset: assert property (@(posedge clk) !rst_n || $rose(rst_n) |->
      !adr_ack && !rsp_ack && !rsp_err && htrans == dmem_pkg::IDLE)
    else note_error("outputs active during or right after reset");

  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      !bus_done |-> !rsp_ack && !rsp_err)
    else note_error("response without a bus completion");

  a_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      bus_done |-> head_valid)
    else note_error("bus completion with no request outstanding");

  a_drop: assert property (@(posedge clk) disable iff (!rst_n)
      bus_done && head_valid && (head_drop || clr) |-> !rsp_ack && !rsp_err)
    else note_error("flushed response reached the CPU");

  a_kind: assert property (@(posedge clk) disable iff (!rst_n)
      bus_done && head_valid && !head_drop && !clr |->
      rsp_ack == !head_err && rsp_err == head_err)
    else value_mismatch("err/ack", {$sampled(head_err), !$sampled(head_err)},
                        {$sampled(rsp_err), $sampled(rsp_ack)});

  a_adr: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_ack || rsp_err |-> rsp_adr == head_adr)
    else value_mismatch("address", $sampled(head_adr), $sampled(rsp_adr));

  a_data: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_ack && !head_we |-> rsp_q == head_q)
    else value_mismatch("read data", $sampled(head_q), $sampled(rsp_q));

  a_pipe: assert property (@(posedge clk) disable iff (!rst_n)
      zero_wait && adr_ack && !clr |=> rsp_ack)
    else note_error("no acknowledge one cycle after acceptance");

  // Address phase carries the offered request
  a_haddr: assert property (@(posedge clk) disable iff (!rst_n)
      htrans == dmem_pkg::NONSEQ |-> haddr == req_adr)
    else value_mismatch("haddr", $sampled(req_adr), $sampled(haddr));

  // Write, word size, SINGLE, zero-extended HPROT, lock
  a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
      htrans == dmem_pkg::NONSEQ |->
      {hwrite, hsize, hburst, hprot, hmastlock} ==
      {req_we, 3'b010, 3'b000, 1'b0, req_prot, req_lock})
    else value_mismatch("control",
                        {$sampled(req_we), 3'b010, 3'b000, 1'b0,
                         $sampled(req_prot), $sampled(req_lock)},
                        {$sampled(hwrite), $sampled(hsize), $sampled(hburst),
                         $sampled(hprot), $sampled(hmastlock)});

  //////////////////////////////
  // Stimulus helpers
  task automatic send_req(input dmem_pkg::plen_t adr, input logic we,
                          input dmem_pkg::xlen_t d);
    req      = 1'b1;
    req_adr  = adr;
    req_we   = we;
    req_d    = d;
    req_prot = adr[4:2];  // Control fields vary with the address
    req_lock = adr[5];
    do begin
      @(posedge clk);
    end while (!adr_ack);  // Held until accepted
    #1;
    req = 1'b0;
  endtask

  task automatic pulse_clr();
    clr = 1'b1;
    @(posedge clk);
    #1;
    clr = 1'b0;
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_base = err_cnt;
  endtask

  // Waits until every accepted request is answered
  task automatic close_test();
    do begin
      @(posedge clk);
      #1;
    end while (exp_q.size() != 0);
    n_tests++;
    if (err_cnt != test_base) begin
      n_failed++;
    end
    $display("test %-9s done, %0d errors", test_name, err_cnt - test_base);
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in test %s, responses missing", cycles, test_name);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  initial begin
    dmem_pkg::plen_t a;
    dmem_pkg::xlen_t d;
    rst_n     = 1'b0;
    req       = 1'b0;
    req_adr   = '0;
    req_we    = 1'b0;
    req_d     = '0;
    req_lock  = 1'b0;
    req_prot  = '0;
    clr       = 1'b0;
    zero_wait = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    open_test("reset");
    repeat (2) @(posedge clk);
    #1;
    close_test();

    open_test("wr_rd");
    d = $random(seed);
    send_req(32'h0000_0040, 1'b1, d);
    send_req(32'h0000_0040, 1'b0, '0);
    send_req(32'h0000_02f0, 1'b0, '0);  // Never written
    close_test();

    open_test("order");
    repeat (NUM_RAND) begin
      a = 32'h0000_0100 + 4 * ({$random(seed)} % 16);
      d = $random(seed);
      send_req(a, d[7], $random(seed));
    end
    close_test();

    open_test("error");
    send_req(32'h0000_1040, 1'b1, 32'hdead_beef);  // Aliases 0x40, must not land
    send_req(32'h0000_1044, 1'b0, '0);
    send_req(32'h0000_0040, 1'b0, '0);
    close_test();

    open_test("flush");
    for (int i = 0; i < 8; i++) begin
      send_req(32'h0000_0180 + 4 * i, 1'b0, '0);
      if (i[0]) begin
        send_req(32'h0000_01c0 + 4 * i, 1'b1, $random(seed));
      end
      pulse_clr();
      send_req(32'h0000_0100, 1'b0, '0);  // Answered normally
    end
    close_test();

    open_test("pipeline");
    zero_wait = 1'b1;
    send_req(32'h0000_0200, 1'b1, $random(seed));
    send_req(32'h0000_0204, 1'b1, $random(seed));
    send_req(32'h0000_0200, 1'b0, '0);
    send_req(32'h0000_0204, 1'b0, '0);
    close_test();
    zero_wait = 1'b0;

    $display("tests %0d, failed %0d, errors %0d, responses %0d",
             n_tests, n_failed, err_cnt, n_resp);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
